// ==== flist.f ====
logic/fbuf_pkg.sv
logic/agu.sv
logic/frame_cfg.sv
logic/capture_ctrl.sv
logic/frame_ram.sv
logic/stream_ctrl.sv
logic/frame_buffer_top.sv
sim/tb_frame_buffer.sv

// ==== logic/agu.sv ====
`timescale 1ns/10ps

module agu import fbuf_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,   // Restart the sequence at address zero
    input  logic  en,      // Step to the next address
    input  addr_t fin,     // Highest address of the sequence
    output addr_t data,
    output logic  last
);

    addr_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (en) begin
            if (count == fin) begin
                count <= '0;   // Wrap so the next pass begins at zero
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign data = count;
    assign last = (count == fin);   // Flags the final address of the frame

endmodule

// ==== logic/capture_ctrl.sv ====
`timescale 1ns/10ps

module capture_ctrl import fbuf_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    src_valid,
    input  data_t   src_data,
    input  addr_t   last_idx,
    input  logic    frame_done,
    output logic    src_ready,
    output ram_wr_t ram_wr,
    output logic    fill_done
);

    cap_state_t state;
    logic       accept;
    addr_t      wr_idx;
    logic       wr_last;

    assign src_ready = (state == FILL);
    assign accept    = src_valid & src_ready;   // A byte moves on this edge

    // Write counter, restarted when the replay of the previous frame ends
    agu i_wr_agu (
        .clk   (clk),
        .rst   (rst),
        .start (frame_done),
        .en    (accept),
        .fin   (last_idx),
        .data  (wr_idx),
        .last  (wr_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL;
        end else begin
            case (state)
                FILL: begin
                    if (accept && wr_last) begin
                        state <= HOLD;   // Buffer holds a full frame
                    end
                end
                HOLD: begin
                    if (frame_done) begin
                        state <= FILL;
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

    // Single cycle pulse raised on the edge that stores the final byte
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= accept & wr_last;
        end
    end

    always_comb begin
        ram_wr.en   = accept;
        ram_wr.addr = wr_idx;
        ram_wr.data = src_data;
    end

endmodule

// ==== logic/fbuf_pkg.sv ====
package fbuf_pkg;

    localparam int ADDR_W = 8;   // Enough to index one full frame
    localparam int DATA_W = 8;
    localparam int DEPTH  = 256;

    typedef logic [ADDR_W-1:0] addr_t;   // Also used for the frame's last index
    typedef logic [DATA_W-1:0] data_t;

    // One write into the frame memory
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } ram_wr_t;

    // Fill side states. FILL accepts source bytes, HOLD waits for the replay to end
    typedef enum logic [0:0] {
        FILL,
        HOLD
    } cap_state_t;

endpackage

// ==== logic/frame_buffer_top.sv ====
`timescale 1ns/10ps

module frame_buffer_top import fbuf_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cfg_we,
    input  addr_t cfg_last,
    input  logic  src_valid,
    input  data_t src_data,
    output logic  src_ready,
    input  logic  dst_ready,
    output logic  dst_valid,
    output logic  dst_last,
    output data_t dst_data
);

    addr_t   last_idx;
    ram_wr_t ram_wr;
    logic    fill_done;
    logic    frame_done;
    logic    stream_v;
    addr_t   stream_a;

    // Frame length, promoted between frames
    frame_cfg i_cfg (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_last   (cfg_last),
        .frame_done (frame_done),
        .last_idx   (last_idx)
    );

    capture_ctrl i_capture (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_data   (src_data),
        .last_idx   (last_idx),
        .frame_done (frame_done),
        .src_ready  (src_ready),
        .ram_wr     (ram_wr),
        .fill_done  (fill_done)
    );

    frame_ram i_ram (
        .clk     (clk),
        .ram_wr  (ram_wr),
        .rd_en   (stream_v),
        .rd_addr (stream_a),
        .rd_data (dst_data)
    );

    stream_ctrl i_stream (
        .clk        (clk),
        .rst        (rst),
        .get_fin    (fill_done),
        .dst_ready  (dst_ready),
        .last_idx   (last_idx),
        .dst_valid  (dst_valid),
        .dst_last   (dst_last),
        .frame_done (frame_done),
        .stream_v   (stream_v),
        .stream_a   (stream_a)
    );

endmodule

// ==== logic/frame_cfg.sv ====
`timescale 1ns/10ps

module frame_cfg import fbuf_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cfg_we,
    input  addr_t cfg_last,
    input  logic  frame_done,
    output addr_t last_idx
);

    addr_t pend_last;   // Written at any time by the host
    addr_t act_last;    // Length of the frame currently in flight

    // The pending copy follows every write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_last <= addr_t'(DEPTH - 1);
        end else if (cfg_we) begin
            pend_last <= cfg_last;
        end
    end

    // Promotion happens only when a replay has finished, so a frame that is
    // being filled or streamed keeps the length it started with
    always_ff @(posedge clk) begin
        if (rst) begin
            act_last <= addr_t'(DEPTH - 1);
        end else if (frame_done) begin
            act_last <= pend_last;
        end
    end

    assign last_idx = act_last;

endmodule

// ==== logic/frame_ram.sv ====
`timescale 1ns/10ps

module frame_ram import fbuf_pkg::*; (
    input  logic    clk,
    input  ram_wr_t ram_wr,
    input  logic    rd_en,
    input  addr_t   rd_addr,
    output data_t   rd_data
);

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // The read register only moves on a read, so the output byte stays
    // put while the stream is stalled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/stream_ctrl.sv ====
`timescale 1ns/10ps

module stream_ctrl import fbuf_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  get_fin,     // Frame stored, from the fill side
    input  logic  dst_ready,
    input  addr_t last_idx,
    output logic  dst_valid,
    output logic  dst_last,
    output logic  frame_done,
    output logic  stream_v,    // Memory read enable
    output addr_t stream_a     // Memory read address
);

    logic  fin_d1;
    logic  fin_d2;
    logic  fin_pend;
    logic  stream_ok;
    logic  armed;
    logic  start;
    logic  active;
    logic  idx_last;
    addr_t rd_idx;

    // Two cycle delay on the fill pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_d1 <= 1'b0;
            fin_d2 <= 1'b0;
        end else begin
            fin_d1 <= get_fin;
            fin_d2 <= fin_d1;
        end
    end

    // A delayed pulse that meets a stalled destination waits here
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_pend <= 1'b0;
        end else if (stream_ok) begin
            fin_pend <= 1'b0;
        end else if (fin_d2) begin
            fin_pend <= 1'b1;
        end
    end

    assign stream_ok = (fin_d2 | fin_pend) & dst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (dst_ready) begin
            armed <= stream_ok;
        end
    end

    assign start = armed & dst_ready;   // Kicks off the read counter

    // Active covers every address of the frame, from zero to last_idx
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (dst_ready) begin
            if (start) begin
                active <= 1'b1;
            end else if (active && idx_last) begin
                active <= 1'b0;   // Final address has just been read
            end
        end
    end

    agu i_rd_agu (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .en    (stream_v),
        .fin   (last_idx),
        .data  (rd_idx),
        .last  (idx_last)
    );

    assign stream_v = active & dst_ready;
    assign stream_a = rd_idx;

    // Valid and last follow the read by one cycle, matching the memory latency
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= active;
            dst_last  <= active & idx_last;
        end
    end

    assign frame_done = dst_last & dst_ready;   // Final byte leaves this cycle

endmodule

// ==== sim/tb_frame_buffer.sv ====
`timescale 1ns/10ps

module tb_frame_buffer import fbuf_pkg::*; ();

    logic  clk;
    logic  rst;
    logic  cfg_we;
    addr_t cfg_last;
    logic  src_valid;
    data_t src_data;
    logic  src_ready;
    logic  dst_ready;
    logic  dst_valid;
    logic  dst_last;
    data_t dst_data;

    integer seed = 32'hb5de8a35;
    int     timeout_cycles = 5000;
    logic   ready_random;          // Destination ready toggles at random when set

    // The reference model of the buffer is updated on every rising edge
    logic [8:0] sb [$];            // Bit 8 marks the last byte of a frame
    logic [8:0] item;
    int         fill_cnt;
    int         act_len;
    int         pend_len;
    logic       exp_fill;
    logic       promote;
    logic       stalled;
    data_t      held_data;
    logic       held_last;
    int         frames_seen;

    frame_buffer_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_last  (cfg_last),
        .src_valid (src_valid),
        .src_data  (src_data),
        .src_ready (src_ready),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_data  (dst_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic value_mismatch(input string name, input int expected, input int actual);
        $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("Finished with errors");
        $fatal(1, "Stopping at the first error");
    endtask

    // Destination ready is either held high or random per cycle
    always @(posedge clk) begin
        if (ready_random) begin
            dst_ready <= $random(seed) & 1;
        end else begin
            dst_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            sb.delete();
            fill_cnt    = 0;
            act_len     = DEPTH;
            pend_len    = DEPTH;
            exp_fill    = 1'b1;
            stalled     = 1'b0;
            frames_seen <= 0;
        end else begin
            assert (src_ready == exp_fill) else value_mismatch("src_ready", exp_fill, src_ready);
            assert (dst_valid || !dst_last) else value_mismatch("dst_last", 0, dst_last);
            if (stalled) begin   // Output must hold while the destination stalls
                assert (dst_valid) else value_mismatch("dst_valid", 1, dst_valid);
                assert (dst_data == held_data)
                    else value_mismatch("dst_data", held_data, dst_data);
                assert (dst_last == held_last)
                    else value_mismatch("dst_last", held_last, dst_last);
            end
            promote = 1'b0;
            if (src_valid && src_ready) begin
                fill_cnt++;
                sb.push_back({fill_cnt == act_len, src_data});
                if (fill_cnt == act_len) begin
                    exp_fill = 1'b0;
                    fill_cnt = 0;
                end
            end
            if (dst_valid && dst_ready) begin
                assert (sb.size() > 0)
                    else abort_run("a byte left the buffer while none was stored");
                item = sb.pop_front();
                assert (dst_data == item[7:0]) else value_mismatch("dst_data", item[7:0], dst_data);
                assert (dst_last == item[8]) else value_mismatch("dst_last", item[8], dst_last);
                if (item[8]) begin
                    promote     = 1'b1;
                    exp_fill    = 1'b1;
                    frames_seen <= frames_seen + 1;
                end
            end
            if (promote) begin
                act_len = pend_len;   // The old pending length wins over a write on this edge
            end
            if (cfg_we) begin
                pend_len = int'(cfg_last) + 1;
            end
            stalled   = dst_valid && !dst_ready;
            held_data = dst_data;
            held_last = dst_last;
        end
    end

    // Sends n random bytes, each held until the buffer takes it
    task automatic send_frame(input int n, input logic gaps);
        int idle;
        int cycles;
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                idle = {$random(seed)} % 4;
                for (int j = 0; j < idle; j++) begin
                    src_valid <= 1'b0;
                    @(posedge clk);
                end
            end
            src_valid <= 1'b1;
            src_data  <= data_t'($random(seed));
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > timeout_cycles) begin
                    abort_run("timed out waiting for the buffer to accept a byte");
                end
            end while (!src_ready);
        end
        src_valid <= 1'b0;
    endtask

    task automatic write_cfg(input addr_t last);
        cfg_we   <= 1'b1;
        cfg_last <= last;
        @(posedge clk);
        cfg_we   <= 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_seen < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timed out waiting for the replay of a frame to end");
            end
        end
    endtask

    task automatic check_ready_dropped();
        @(posedge clk);
        assert (src_ready == 1'b0) else value_mismatch("src_ready", 0, src_ready);
    endtask

    task automatic idle_after_reset();
        @(posedge clk);
        assert (dst_valid == 1'b0) else value_mismatch("dst_valid", 0, dst_valid);
        assert (dst_last == 1'b0) else value_mismatch("dst_last", 0, dst_last);
        assert (src_ready == 1'b1) else value_mismatch("src_ready", 1, src_ready);
    endtask

    task automatic full_frame_ready_high();
        ready_random <= 1'b0;
        send_frame(DEPTH, 1'b0);
        check_ready_dropped();
        wait_frames(1);
    endtask

    task automatic random_ready_stalls();
        ready_random <= 1'b1;
        send_frame(DEPTH, 1'b0);
        wait_frames(2);
        ready_random <= 1'b0;
    endtask

    task automatic source_with_gaps();
        send_frame(DEPTH, 1'b1);
        check_ready_dropped();
        wait_frames(3);
    endtask

    // The new length is written while a full frame is still streaming out
    task automatic length_change_midframe();
        send_frame(DEPTH, 1'b0);
        check_ready_dropped();
        write_cfg(addr_t'(15));
        wait_frames(4);
        ready_random <= 1'b1;
        send_frame(16, 1'b1);
        check_ready_dropped();
        wait_frames(5);
        ready_random <= 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        cfg_we       = 1'b0;
        cfg_last     = '0;
        src_valid    = 1'b0;
        src_data     = '0;
        dst_ready    = 1'b0;
        ready_random = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        full_frame_ready_high();
        random_ready_stalls();
        source_with_gaps();
        length_change_midframe();
        $display("Finished with no errors");
        $finish;
    end

endmodule
